// ==== src.f ====
verilog/i3c_rx_pkg.sv
verilog/sync_fifo.sv
verilog/private_write_rx.sv
verilog/descriptor_rx.sv
verilog/i3c_rx_top.sv
bench/rx_checker.sv
bench/tb_i3c_rx.sv

// ==== Bender.yml ====
package:
  name: i3c_rx

sources:
  # rtl, package first
  - files:
      - verilog/i3c_rx_pkg.sv
      - verilog/sync_fifo.sv
      - verilog/private_write_rx.sv
      - verilog/descriptor_rx.sv
      - verilog/i3c_rx_top.sv

  # testbench
  - target: test
    files:
      - bench/rx_checker.sv
      - bench/tb_i3c_rx.sv

// ==== bench/tb_i3c_rx.sv ====
// rx path testbench; bytes come from $urandom with a fixed seed, queues are popped only between transfers
`timescale 1ns/1ps

module tb_i3c_rx;

  import i3c_rx_pkg::*;

  localparam int NumTests   = 14;
  localparam int HalfPeriod = 50;
  localparam int DriveDelay = 5;
  localparam int ResetCycles = 5;
  localparam int Seed       = 50058;

  // one table row: byte count, idle cycle mask, drain after the transfer
  typedef struct packed {
    logic [7:0] nbytes;
    logic [7:0] gap;
    logic       drain;
  } test_row_t;

  logic                   clk;
  logic                   rst_n;
  logic [RxDataWidth-1:0] bus_byte;
  logic                   bus_byte_valid;
  logic                   bus_stop;
  logic                   data_pop;
  logic [RxDataWidth-1:0] data;
  logic                   data_empty;
  logic                   desc_pop;
  rx_desc_t               desc;
  logic                   desc_empty;

  // bench to checker
  logic test_end;
  logic drained;
  int   test_id;

  // checker counts
  int test_cnt;
  int fail_cnt;
  int check_cnt;
  int err_cnt;

  test_row_t tests [NumTests];
  int        cycle_limit;
  logic      limit_ready;

  i3c_rx_top dut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .bus_byte_i       (bus_byte),
    .bus_byte_valid_i (bus_byte_valid),
    .bus_stop_i       (bus_stop),
    .data_pop_i       (data_pop),
    .data_o           (data),
    .data_empty_o     (data_empty),
    .desc_pop_i       (desc_pop),
    .desc_o           (desc),
    .desc_empty_o     (desc_empty)
  );

  rx_checker u_check (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .bus_byte_i       (bus_byte),
    .bus_byte_valid_i (bus_byte_valid),
    .bus_stop_i       (bus_stop),
    .data_pop_i       (data_pop),
    .data_i           (data),
    .data_empty_i     (data_empty),
    .desc_pop_i       (desc_pop),
    .desc_i           (desc),
    .desc_empty_i     (desc_empty),
    .test_end_i       (test_end),
    .test_id_i        (test_id),
    .drained_i        (drained),
    .test_cnt_o       (test_cnt),
    .fail_cnt_o       (fail_cnt),
    .check_cnt_o      (check_cnt),
    .err_cnt_o        (err_cnt)
  );

  // 100 ns clock
  always #(HalfPeriod) clk = ~clk;

  // rows 0..7 single transfers, 8 fills the queue exactly, 9 and 10 overflow
  // rows 11..13 are back to back, drained after the last one
  task automatic load_tests();
    tests[0]  = {8'd1,  8'h00, 1'b1};
    tests[1]  = {8'd2,  8'h55, 1'b1};
    tests[2]  = {8'd3,  8'h00, 1'b1};
    tests[3]  = {8'd4,  8'h0f, 1'b1};
    tests[4]  = {8'd5,  8'haa, 1'b1};
    tests[5]  = {8'd6,  8'h00, 1'b1};
    tests[6]  = {8'd7,  8'h33, 1'b1};
    tests[7]  = {8'd0,  8'h00, 1'b1};
    tests[8]  = {8'd8,  8'h00, 1'b1};
    tests[9]  = {8'd11, 8'h00, 1'b1};
    tests[10] = {8'd11, 8'h24, 1'b1};
    tests[11] = {8'd2,  8'h00, 1'b0};
    tests[12] = {8'd3,  8'h11, 1'b0};
    tests[13] = {8'd1,  8'h00, 1'b1};
  endtask

  // next edge plus drive skew
  task automatic step();
    @(posedge clk);
    #(DriveDelay);
  endtask

  // bytes with optional idle cycles, then the stop strobe
  task automatic send_transfer(input test_row_t row);
    int rnd;
    for (int b = 0; b < row.nbytes; b++) begin
      rnd            = $urandom;
      bus_byte       = rnd[RxDataWidth-1:0];
      bus_byte_valid = 1'b1;
      step();
      bus_byte_valid = 1'b0;
      if (row.gap[b % 8]) begin
        step();
      end
    end
    bus_stop = 1'b1;
    step();
    bus_stop = 1'b0;
  endtask

  // descriptors first, so every byte has landed before the data drain
  task automatic drain_queues(input int pend_desc);
    for (int k = 0; k < pend_desc; k++) begin
      while (desc_empty) begin
        step();
      end
      desc_pop = 1'b1;
      step();
      desc_pop = 1'b0;
    end
    while (!data_empty) begin
      data_pop = 1'b1;
      step();
    end
    data_pop = 1'b0;
  endtask

  // one cycle strobe, checker closes the test on it
  task automatic end_test(input int id, input logic was_drained);
    test_id  = id;
    drained  = was_drained;
    test_end = 1'b1;
    step();
    test_end = 1'b0;
  endtask

  initial begin : stimulus
    int rnd;
    int total;
    int pend_desc;
    clk            = 1'b0;
    rst_n          = 1'b0;
    bus_byte       = '0;
    bus_byte_valid = 1'b0;
    bus_stop       = 1'b0;
    data_pop       = 1'b0;
    desc_pop       = 1'b0;
    test_end       = 1'b0;
    drained        = 1'b0;
    test_id        = 0;
    limit_ready    = 1'b0;
    pend_desc      = 0;
    rnd = $urandom(Seed);
    load_tests();
    // bytes take up to two cycles each, drains and waits fit in the per row slack
    total = 0;
    for (int i = 0; i < NumTests; i++) begin
      total += tests[i].nbytes;
    end
    cycle_limit = 50 + 3 * total + 30 * NumTests;
    limit_ready = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    #(DriveDelay);
    rst_n = 1'b1;
    step();
    // test 0, pops on the empty queues after reset
    data_pop = 1'b1;
    desc_pop = 1'b1;
    step();
    data_pop = 1'b0;
    desc_pop = 1'b0;
    end_test(0, 1'b1);
    for (int i = 0; i < NumTests; i++) begin
      send_transfer(tests[i]);
      pend_desc++;
      if (tests[i].drain) begin
        drain_queues(pend_desc);
        pend_desc = 0;
      end
      end_test(i + 1, tests[i].drain);
    end
    step();
    $display("tests: %0d, failed: %0d, checks: %0d, errors: %0d",
             test_cnt, fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0 && test_cnt == NumTests + 1) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // cycle counter against the limit from the table
  initial begin : watchdog
    int cycles;
    cycles = 0;
    wait (limit_ready);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== bench/rx_checker.sv ====
// reference model of both queues; correct only while pops never overlap a transfer in flight
`timescale 1ns/1ps

module rx_checker (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic [i3c_rx_pkg::RxDataWidth-1:0] bus_byte_i,
  input  logic                               bus_byte_valid_i,
  input  logic                               bus_stop_i,
  input  logic                               data_pop_i,
  input  logic [i3c_rx_pkg::RxDataWidth-1:0] data_i,
  input  logic                               data_empty_i,
  input  logic                               desc_pop_i,
  input  i3c_rx_pkg::rx_desc_t               desc_i,
  input  logic                               desc_empty_i,
  input  logic                               test_end_i,
  input  int                                 test_id_i,
  input  logic                               drained_i,
  output int                                 test_cnt_o,
  output int                                 fail_cnt_o,
  output int                                 check_cnt_o,
  output int                                 err_cnt_o
);

  import i3c_rx_pkg::*;

  // expected queue contents
  logic [RxDataWidth-1:0] exp_data_q [$];
  logic [31:0]            exp_desc_q [$];

  // model transfer state
  logic dropping;
  int   cur_len;
  int   test_errs;
  int   test_checks;

  initial begin
    dropping    = 1'b0;
    cur_len     = 0;
    test_errs   = 0;
    test_checks = 0;
    test_cnt_o  = 0;
    fail_cnt_o  = 0;
    check_cnt_o = 0;
    err_cnt_o   = 0;
  end

  task automatic report_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    err_cnt_o++;
    test_errs++;
  endtask

  // a byte fits if the queue has room, else the transfer ends with overflow
  task automatic model_byte(input logic [RxDataWidth-1:0] b);
    if (!dropping) begin
      if (exp_data_q.size() < RxDataDepth) begin
        exp_data_q.push_back(b);
        cur_len++;
      end else begin
        exp_desc_q.push_back({RxErrOverflow, 12'h000, cur_len[15:0]});
        dropping = 1'b1;
        cur_len  = 0;
      end
    end
  endtask

  // stop after an overflow adds nothing
  task automatic model_stop();
    if (!dropping) begin
      exp_desc_q.push_back({RxErrNone, 12'h000, cur_len[15:0]});
    end
    dropping = 1'b0;
    cur_len  = 0;
  endtask

  task automatic check_data_pop();
    test_checks++;
    check_cnt_o++;
    if (exp_data_q.size() == 0) begin
      if (!data_empty_i) begin
        report_error($sformatf("data queue holds 0x%02h, none expected", data_i));
      end
    end else if (data_empty_i) begin
      report_error($sformatf("data queue empty, expected 0x%02h", exp_data_q[0]));
      void'(exp_data_q.pop_front());
    end else begin
      if (data_i !== exp_data_q[0]) begin
        report_error($sformatf("data byte 0x%02h, expected 0x%02h", data_i, exp_data_q[0]));
      end
      void'(exp_data_q.pop_front());
    end
  endtask

  task automatic check_desc_pop();
    test_checks++;
    check_cnt_o++;
    if (exp_desc_q.size() == 0) begin
      if (!desc_empty_i) begin
        report_error($sformatf("descriptor 0x%08h popped, none expected", desc_i));
      end
    end else if (desc_empty_i) begin
      report_error($sformatf("descriptor queue empty, expected length %0d err %0d",
                             exp_desc_q[0][15:0], exp_desc_q[0][31:28]));
      void'(exp_desc_q.pop_front());
    end else begin
      if (desc_i !== exp_desc_q[0]) begin
        report_error($sformatf("descriptor length %0d err %0d, expected length %0d err %0d",
                               desc_i.length, desc_i.err,
                               exp_desc_q[0][15:0], exp_desc_q[0][31:28]));
      end
      void'(exp_desc_q.pop_front());
    end
  endtask

  // after a drain both queues must be empty, in the model and in the DUT
  task automatic close_test();
    if (drained_i) begin
      if (data_empty_i !== 1'b1) begin
        report_error("data queue not empty after drain");
      end
      if (desc_empty_i !== 1'b1) begin
        report_error("descriptor queue not empty after drain");
      end
      if (exp_data_q.size() != 0) begin
        report_error($sformatf("%0d expected bytes never popped", exp_data_q.size()));
        exp_data_q.delete();
      end
      if (exp_desc_q.size() != 0) begin
        report_error($sformatf("%0d expected descriptors never popped", exp_desc_q.size()));
        exp_desc_q.delete();
      end
    end
    test_cnt_o++;
    if (test_errs == 0) begin
      $display("test %0d: ok, %0d checks", test_id_i, test_checks);
    end else begin
      $display("test %0d: failed with %0d errors", test_id_i, test_errs);
      fail_cnt_o++;
    end
    test_errs   = 0;
    test_checks = 0;
  endtask

  // inputs settle well before the edge, outputs are registered or combinational from state
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (bus_byte_valid_i) begin
        model_byte(bus_byte_i);
      end
      if (bus_stop_i) begin
        model_stop();
      end
      if (data_pop_i) begin
        check_data_pop();
      end
      if (desc_pop_i) begin
        check_desc_pop();
      end
      if (test_end_i) begin
        close_test();
      end
    end
  end

endmodule

// ==== verilog/i3c_rx_top.sv ====
// rx path top; pops on an empty queue are ignored, a descriptor push into a full queue is an error
`timescale 1ns/1ps

module i3c_rx_top (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic [i3c_rx_pkg::RxDataWidth-1:0]   bus_byte_i,
  input  logic                                 bus_byte_valid_i,
  input  logic                                 bus_stop_i,
  input  logic                                 data_pop_i,
  output logic [i3c_rx_pkg::RxDataWidth-1:0]   data_o,
  output logic                                 data_empty_o,
  input  logic                                 desc_pop_i,
  output i3c_rx_pkg::rx_desc_t                 desc_o,
  output logic                                 desc_empty_o
);

  import i3c_rx_pkg::*;

  // framer to descriptor_rx
  rx_byte_t               rx_byte;
  logic                   rx_byte_valid;
  logic                   rx_byte_ready;

  // data queue write side
  logic                   data_wr;
  logic [RxDataWidth-1:0] data_wdata;
  logic                   data_full;

  // descriptor queue write side
  logic                   desc_wr;
  rx_desc_t               desc_wdata;
  logic                   desc_full;

  private_write_rx u_framer (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .bus_byte_i       (bus_byte_i),
    .bus_byte_valid_i (bus_byte_valid_i),
    .bus_stop_i       (bus_stop_i),
    .rx_ready_i       (rx_byte_ready),
    .rx_byte_o        (rx_byte),
    .rx_byte_valid_o  (rx_byte_valid)
  );

  descriptor_rx u_desc_rx (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rx_byte_i       (rx_byte),
    .rx_byte_valid_i (rx_byte_valid),
    .rx_byte_ready_o (rx_byte_ready),
    .data_full_i     (data_full),
    .data_wr_o       (data_wr),
    .data_wdata_o    (data_wdata),
    .desc_full_i     (desc_full),
    .desc_wr_o       (desc_wr),
    .desc_wdata_o    (desc_wdata)
  );

  // byte queue read by software
  sync_fifo #(
    .Width (RxDataWidth),
    .Depth (RxDataDepth)
  ) u_data_q (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wr_i    (data_wr),
    .wdata_i (data_wdata),
    .rd_i    (data_pop_i),
    .rdata_o (data_o),
    .full_o  (data_full),
    .empty_o (data_empty_o)
  );

  // descriptor queue, one word per transfer
  sync_fifo #(
    .Width ($bits(rx_desc_t)),
    .Depth (RxDescDepth)
  ) u_desc_q (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wr_i    (desc_wr),
    .wdata_i (desc_wdata),
    .rd_i    (desc_pop_i),
    .rdata_o (desc_o),
    .full_o  (desc_full),
    .empty_o (desc_empty_o)
  );

endmodule

// ==== verilog/descriptor_rx.sv ====
// builds one descriptor per transfer; expects the framer to hold bytes back while the data queue is full
`timescale 1ns/1ps

module descriptor_rx (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  i3c_rx_pkg::rx_byte_t                 rx_byte_i,
  input  logic                                 rx_byte_valid_i,
  output logic                                 rx_byte_ready_o,
  input  logic                                 data_full_i,
  output logic                                 data_wr_o,
  output logic [i3c_rx_pkg::RxDataWidth-1:0]   data_wdata_o,
  input  logic                                 desc_full_i,
  output logic                                 desc_wr_o,
  output i3c_rx_pkg::rx_desc_t                 desc_wdata_o
);

  import i3c_rx_pkg::*;

  logic [RxLenWidth-1:0] byte_cnt_q;
  logic [RxLenWidth-1:0] len_q;
  rx_err_e               err_q;
  logic                  push_q;

  logic is_data;
  logic is_end;

  // ready is just the queue level
  assign rx_byte_ready_o = ~data_full_i;

  // split framed items into data and end markers
  assign is_data = rx_byte_valid_i & ~rx_byte_i.last & ~rx_byte_i.err;
  assign is_end  = rx_byte_valid_i & (rx_byte_i.last | rx_byte_i.err);

  // data goes to the queue the same cycle
  assign data_wr_o    = is_data;
  assign data_wdata_o = rx_byte_i.data;

  // byte counter and push strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_cnt_q <= '0;
      push_q     <= 1'b0;
    end else begin
      push_q <= is_end;
      // a byte of the next transfer may land in the push cycle
      if (push_q) begin
        byte_cnt_q <= is_data ? RxLenWidth'(1) : '0;
      end else if (is_data) begin
        byte_cnt_q <= byte_cnt_q + 1'b1;
      end
    end
  end

  // latched length and error code for the pending descriptor
  always_ff @(posedge clk_i) begin
    if (is_end) begin
      len_q <= byte_cnt_q;
      err_q <= rx_byte_i.err ? RxErrOverflow : RxErrNone;
    end
  end

  // descriptor word
  always_comb begin
    desc_wdata_o          = '0;
    desc_wdata_o.err      = err_q;
    desc_wdata_o.length   = len_q;
  end

  assign desc_wr_o = push_q;

  // framer must respect the ready level
  a_no_data_wr_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    data_wr_o |-> !data_full_i
  ) else $error("descriptor_rx: data write into full queue");

  // software must drain descriptors in time
  a_no_desc_wr_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    desc_wr_o |-> !desc_full_i
  ) else $error("descriptor_rx: descriptor push into full queue");

endmodule

// ==== verilog/private_write_rx.sv ====
// framer for private writes; byte and stop strobes must not coincide, bytes after an overflow are lost until stop
`timescale 1ns/1ps

module private_write_rx (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic [i3c_rx_pkg::RxDataWidth-1:0]   bus_byte_i,
  input  logic                                 bus_byte_valid_i,
  input  logic                                 bus_stop_i,
  input  logic                                 rx_ready_i,
  output i3c_rx_pkg::rx_byte_t                 rx_byte_o,
  output logic                                 rx_byte_valid_o
);

  import i3c_rx_pkg::*;

  logic [RxDataWidth-1:0] byte_q;
  logic                   byte_pend_q;
  logic                   stop_pend_q;
  logic                   drop_q;

  logic overflow;
  logic accept_byte;
  logic accept_stop;
  logic end_drop;

  // registered byte meets a full queue
  // ready is sampled in the same cycle the write would happen,
  // so a byte still in flight is already accounted for
  assign overflow = byte_pend_q & ~rx_ready_i;

  // bytes ignored while dropping or while the overflow marker goes out
  assign accept_byte = bus_byte_valid_i & ~drop_q & ~overflow;

  // stop after an overflow ends the transfer silently
  assign end_drop    = bus_stop_i & (drop_q | overflow);
  assign accept_stop = bus_stop_i & ~drop_q & ~overflow;

  // control state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_pend_q <= 1'b0;
      stop_pend_q <= 1'b0;
      drop_q      <= 1'b0;
    end else begin
      byte_pend_q <= accept_byte;
      stop_pend_q <= accept_stop;
      // stop wins over a fresh overflow
      if (end_drop) begin
        drop_q <= 1'b0;
      end else if (overflow) begin
        drop_q <= 1'b1;
      end
    end
  end

  // payload byte
  always_ff @(posedge clk_i) begin
    if (accept_byte) begin
      byte_q <= bus_byte_i;
    end
  end

  // framed item
  // data only on a byte that fits, markers carry zero
  always_comb begin
    rx_byte_o = '0;
    if (byte_pend_q && rx_ready_i) begin
      rx_byte_o.data = byte_q;
    end
    rx_byte_o.last = stop_pend_q;
    rx_byte_o.err  = overflow;
  end

  assign rx_byte_valid_o = byte_pend_q | stop_pend_q;

  // bus side never strobes byte and stop together
  a_no_byte_and_stop: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(bus_byte_valid_i && bus_stop_i)
  ) else $error("private_write_rx: byte and stop in same cycle");

endmodule

// ==== verilog/sync_fifo.sv ====
// single clock queue; head word is combinational, writes when full and reads when empty are dropped
`timescale 1ns/1ps

module sync_fifo #(
  parameter int unsigned Width = 8,
  parameter int unsigned Depth = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             wr_i,
  input  logic [Width-1:0] wdata_i,
  input  logic             rd_i,
  output logic [Width-1:0] rdata_o,
  output logic             full_o,
  output logic             empty_o
);

  // pointer needs at least one bit even for a single entry
  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  // count spans 0..Depth
  localparam int unsigned CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wr_ptr_q;
  logic [PtrW-1:0]  rd_ptr_q;
  logic [CntW-1:0]  cnt_q;

  logic do_wr;
  logic do_rd;

  // qualified strobes
  assign do_wr = wr_i & ~full_o;
  assign do_rd = rd_i & ~empty_o;

  assign full_o  = (cnt_q == CntW'(Depth));
  assign empty_o = (cnt_q == '0);

  // head of queue straight from storage
  assign rdata_o = mem_q[rd_ptr_q];

  // pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // wrap at Depth, which need not be a power of two
      if (do_wr) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_rd) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous read and write leaves count alone
      case ({do_wr, do_rd})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  // occupancy bound
  a_cnt_bound: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= CntW'(Depth)
  ) else $error("sync_fifo: count above depth");

endmodule

// ==== verilog/i3c_rx_pkg.sv ====
// rx path constants and types; error codes are 4 bits and only none/overflow are produced

package i3c_rx_pkg;

  // data queue entry width, one bus byte per entry
  localparam int unsigned RxDataWidth = 8;

  // kept small so a single transfer can overflow it
  localparam int unsigned RxDataDepth = 8;

  // descriptor queue entries
  localparam int unsigned RxDescDepth = 4;

  // byte counter and descriptor length field
  localparam int unsigned RxLenWidth = 16;

  // descriptor error codes
  typedef enum logic [3:0] {
    RxErrNone     = 4'h0,
    RxErrOverflow = 4'h1
  } rx_err_e;

  // one rx descriptor, 32 bits
  // err sits in the top nibble, length in the low half
  typedef struct packed {
    rx_err_e                err;
    logic [11:0]            reserved;
    logic [RxLenWidth-1:0]  length;
  } rx_desc_t;

  // framed byte from the framer to descriptor_rx
  // end markers carry zero data
  // last marks a normal stop, err marks an overflow end
  typedef struct packed {
    logic [RxDataWidth-1:0] data;
    logic                   last;
    logic                   err;
  } rx_byte_t;

endpackage
